// ==== src/snake_frame_pkg.sv ====
`default_nettype none

package snake_frame_pkg;

    // Playfield size in cells
    localparam int grid_w = 16;
    localparam int grid_h = 12;

    localparam int max_body = 8; // Body segment slots in a scene

    // Credits granted by the display after reset, also the sender queue depth
    localparam int display_credits = 4;

    typedef logic [3:0] coord_t;    // Cell column or row
    typedef logic [3:0] body_cnt_t; // Number of valid body slots
    typedef logic [2:0] credit_t;   // Credits held, 0 up to display_credits
    typedef logic [2:0] q_cnt_t;    // Queue occupancy, 0 up to display_credits
    typedef logic [1:0] q_ptr_t;    // Queue slot index

    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_pos_t;

    typedef struct packed {
        cell_pos_t                   head;
        cell_pos_t [max_body-1:0]    body;
        body_cnt_t                   body_count;
        cell_pos_t                   apple;
        logic                        apple_valid;
    } snake_scene_t;

    typedef struct packed {
        obj_code_t code;
        cell_pos_t pos;
    } cell_update_t;

endpackage

`default_nettype wire

// ==== src/cell_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module cell_classifier import snake_frame_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  snake_scene_t scene,
    input  logic         scene_load,
    input  cell_pos_t    scan_pos,
    output obj_code_t    obj
);

    snake_scene_t scene_q;
    logic         on_ring;
    logic         head_hit;
    logic         body_hit;
    logic         apple_hit;

    // Held scene, an empty snake with no apple after reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scene_q <= '0;
        end else if (scene_load) begin
            scene_q <= scene;
        end
    end

    // Outer ring of the field
    assign on_ring = (scan_pos.x == coord_t'(0)) ||
                     (scan_pos.x == coord_t'(grid_w - 1)) ||
                     (scan_pos.y == coord_t'(0)) ||
                     (scan_pos.y == coord_t'(grid_h - 1));

    assign head_hit  = (scene_q.head == scan_pos);
    assign apple_hit = scene_q.apple_valid && (scene_q.apple == scan_pos);

    always_comb begin
        body_hit = 1'b0;
        for (int i = 0; i < max_body; i++) begin
            // Only slots below body_count hold live segments
            if ((body_cnt_t'(i) < scene_q.body_count) && (scene_q.body[i] == scan_pos)) begin
                body_hit = 1'b1;
            end
        end
    end

    // Border wins over head, head over body, body over apple
    always_comb begin
        if (on_ring) begin
            obj = border_c;
        end else if (head_hit) begin
            obj = snake_head;
        end else if (body_hit) begin
            obj = snake_body;
        end else if (apple_hit) begin
            obj = apple_c;
        end else begin
            obj = blank;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_tracker import snake_frame_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  obj_code_t    obj,
    input  logic         ready,
    output cell_pos_t    scan_pos,
    output logic         upd_valid,
    output cell_update_t upd
);

    // Codes last sent to the display, indexed by column then row
    obj_code_t frame [grid_w][grid_h];
    obj_code_t cur_code;
    cell_pos_t next_pos;
    logic      last_col;
    logic      last_row;

    assign cur_code = frame[scan_pos.x][scan_pos.y];

    assign last_col = (scan_pos.x == coord_t'(grid_w - 1));
    assign last_row = (scan_pos.y == coord_t'(grid_h - 1));

    // Raster order, wrapping from the bottom right cell back to (0,0)
    always_comb begin
        next_pos = scan_pos;
        if (last_col) begin
            next_pos.x = '0;
            if (last_row) begin
                next_pos.y = '0;
            end else begin
                next_pos.y = scan_pos.y + coord_t'(1);
            end
        end else begin
            next_pos.x = scan_pos.x + coord_t'(1);
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scan_pos <= '0;
        end else if (ready) begin
            scan_pos <= next_pos;
        end
    end

    // Frame starts blank so the first scan paints everything that is not empty
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < grid_w; i++) begin
                for (int j = 0; j < grid_h; j++) begin
                    frame[i][j] <= blank;
                end
            end
        end else if (ready) begin
            frame[scan_pos.x][scan_pos.y] <= obj; // Commit only on a scan step
        end
    end

    // The held update is taken by the sender on any ready cycle, so a new one
    // can be loaded on the same edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            upd_valid <= 1'b0;
        end else if (ready) begin
            upd_valid <= (obj != cur_code);
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            upd.code <= obj;
            upd.pos  <= scan_pos;
        end
    end

endmodule

`default_nettype wire

// ==== src/update_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module update_sender import snake_frame_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  logic         upd_valid,
    input  cell_update_t upd,
    output logic         ready,
    input  logic         credit_return,
    output logic         out_valid,
    output cell_update_t out_upd
);

    cell_update_t mem [display_credits];
    q_ptr_t       wr_ptr;
    q_ptr_t       rd_ptr;
    q_cnt_t       count;
    credit_t      credits;
    logic         push;
    logic         pop;
    cell_update_t head_upd;

    assign ready = (count < q_cnt_t'(display_credits));
    assign push  = upd_valid && ready;

    // An empty queue lets a new update go straight to the output stage
    assign pop      = ((count != '0) || push) && (credits != '0);
    assign head_upd = (count != '0) ? mem[rd_ptr] : upd;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= upd;
        end
        if (pop) begin
            out_upd <= head_upd;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop; // One cycle per update sent
            if (push) begin
                wr_ptr <= wr_ptr + q_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + q_ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + q_cnt_t'(1);
                2'b01:   count <= count - q_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // A credit is spent with each send and comes back with each return pulse
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credits <= credit_t'(display_credits);
        end else begin
            case ({pop, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/snake_frame_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_frame_top import snake_frame_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  snake_scene_t scene,
    input  logic         scene_load,
    input  logic         credit_return,
    output logic         out_valid,
    output cell_update_t out_upd
);

    cell_pos_t    scan_pos;
    obj_code_t    obj;
    logic         upd_valid;
    cell_update_t upd;
    logic         ready;

    cell_classifier i_classifier (
        .clk        (clk),
        .nrst       (nrst),
        .scene      (scene),
        .scene_load (scene_load),
        .scan_pos   (scan_pos),
        .obj        (obj)
    );

    // Scan stalls whenever the sender queue is full
    frame_tracker i_tracker (
        .clk       (clk),
        .nrst      (nrst),
        .obj       (obj),
        .ready     (ready),
        .scan_pos  (scan_pos),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    update_sender i_sender (
        .clk           (clk),
        .nrst          (nrst),
        .upd_valid     (upd_valid),
        .upd           (upd),
        .ready         (ready),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_upd       (out_upd)
    );

endmodule

`default_nettype wire

// ==== dv/snake_frame_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_frame_assertions import snake_frame_pkg::*; (
    input logic         clk,
    input logic         nrst,
    input logic         ready,
    input logic         upd_valid,
    input cell_update_t upd,
    input logic         credit_return,
    input credit_t      credits
);

    // A return with every credit already home means the display overpaid
    a_return_outstanding: assert property (@(posedge clk) disable iff (!nrst)
        credit_return |-> credits < credit_t'(display_credits))
        else $error("credit returned with no update outstanding");

    // A stalled update stays offered unchanged until the queue frees a slot
    a_stall_holds_update: assert property (@(posedge clk) disable iff (!nrst)
        upd_valid && !ready |=> upd_valid && $stable(upd))
        else $error("offered update changed while the queue was full");

    a_credit_releases_stall: assert property (@(posedge clk) disable iff (!nrst)
        !ready && credits != '0 |=> ready)
        else $error("queue stayed full although credits were available");

endmodule

`default_nettype wire

// ==== dv/snake_frame_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_frame_tb import snake_frame_pkg::*; ();

    logic         clk = 1'b0;
    logic         nrst;
    snake_scene_t scene;
    logic         scene_load;
    logic         credit_return;
    logic         out_valid;
    cell_update_t out_upd;

    snake_scene_t scenes [$];
    int           delays [$];
    int           n_scenes = 0;
    int           cur_delay = 0;   // Longest credit return delay for the running scene
    int           cyc_no = 0;
    int           last_upd = 0;    // Cycle of the most recent update at the display
    int           received = 0;
    int           returned = 0;
    int           err_stream = 0;
    int           err_frame = 0;
    logic [31:0]  lfsr = 32'had1c0348;

    // Cell arrays are indexed by the packed position {x, y}
    obj_code_t    disp [256];
    obj_code_t    prev_disp [256];
    obj_code_t    exp_frame [256];
    int           upd_total [256];
    int           base_cnt [256];

    always #10 clk = ~clk;

    snake_frame_top i_dut (
        .clk           (clk),
        .nrst          (nrst),
        .scene         (scene),
        .scene_load    (scene_load),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_upd       (out_upd)
    );

    bind update_sender snake_frame_assertions i_sender_sva (
        .clk           (clk),
        .nrst          (nrst),
        .ready         (ready),
        .upd_valid     (upd_valid),
        .upd           (upd),
        .credit_return (credit_return),
        .credits       (credits)
    );

    // Lowest priority first, so each later match overrides the earlier ones
    function automatic obj_code_t model_code(input snake_scene_t s, input cell_pos_t p);
        obj_code_t c;
        c = blank;
        if (s.apple_valid && s.apple == p) c = apple_c;
        for (int i = 0; i < max_body; i++) begin
            if (body_cnt_t'(i) < s.body_count && s.body[3'(i)] == p) c = snake_body;
        end
        if (s.head == p) c = snake_head;
        if (p.x == coord_t'(0) || p.x == coord_t'(grid_w - 1) ||
            p.y == coord_t'(0) || p.y == coord_t'(grid_h - 1)) begin
            c = border_c;
        end
        return c;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // Seven fresh bits per draw, folded into 0 up to max_d
    task automatic draw_delay(input int max_d, output int d);
        logic [6:0] r;
        r = '0;
        for (int i = 0; i < 7; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[5:0], lfsr[0]};
        end
        d = int'(r) % (max_d + 1);
    endtask

    task automatic read_scenes(output bit ok);
        int           fd;
        int           n;
        string        line;
        int           v [23];
        snake_scene_t s;
        fd = $fopen("dv/snake_frame_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != 8'h23) begin // Lines starting with # are notes
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                        v[19], v[20], v[21], v[22]);
                    if (n == 23) begin
                        s = '0;
                        s.head.x      = coord_t'(v[0]);
                        s.head.y      = coord_t'(v[1]);
                        s.apple.x     = coord_t'(v[2]);
                        s.apple.y     = coord_t'(v[3]);
                        s.apple_valid = v[4][0];
                        s.body_count  = body_cnt_t'(v[5]);
                        for (int i = 0; i < max_body; i++) begin
                            s.body[3'(i)].x = coord_t'(v[6 + 2 * i]);
                            s.body[3'(i)].y = coord_t'(v[7 + 2 * i]);
                        end
                        scenes.push_back(s);
                        delays.push_back(v[22]);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (scenes.size() > 0);
    endtask

    // Two scans plus slack, then hold until the display has been idle a while
    task automatic wait_quiet();
        repeat (2 * grid_w * grid_h + 64) @(posedge clk);
        while (cyc_no - last_upd < 400) @(posedge clk);
    endtask

    task automatic run_scene(input int idx);
        cell_pos_t p;
        int        exp_cnt;
        for (int k = 0; k < 256; k++) begin
            p = k[7:0];
            prev_disp[p] = disp[p];
            base_cnt[p]  = upd_total[p];
            exp_frame[p] = model_code(scenes[idx], p);
        end
        cur_delay = delays[idx];
        @(posedge clk);
        #1;
        scene      = scenes[idx];
        scene_load = 1'b1;
        @(posedge clk);
        #1;
        scene_load = 1'b0;
        wait_quiet();
        for (int k = 0; k < 256; k++) begin
            p = k[7:0];
            if (p.y < coord_t'(grid_h)) begin
                exp_cnt = (prev_disp[p] != exp_frame[p]) ? 1 : 0;
                if (disp[p] != exp_frame[p]) begin
                    err_frame++;
                    $display("ERR %0t: scene %0d cell (%0d,%0d) shows %0d, expected %0d",
                             $time, idx, p.x, p.y, disp[p], exp_frame[p]);
                end
                if (upd_total[p] - base_cnt[p] != exp_cnt) begin
                    err_frame++;
                    $display("ERR %0t: scene %0d cell (%0d,%0d) got %0d updates, expected %0d",
                             $time, idx, p.x, p.y, upd_total[p] - base_cnt[p], exp_cnt);
                end
            end
        end
    endtask

    // Display model, takes updates at the falling edge and pays credits back in order
    initial begin
        cell_pos_t p;
        int        d;
        int        due;
        int        last_due;
        int        due_q [$];
        credit_return = 1'b0;
        last_due = 0;
        for (int k = 0; k < 256; k++) disp[k[7:0]] = blank;
        forever begin
            @(negedge clk);
            if (nrst && out_valid) begin
                p = out_upd.pos;
                if (p.y >= coord_t'(grid_h)) begin
                    err_stream++;
                    $display("ERR %0t: update for cell (%0d,%0d) outside the field",
                             $time, p.x, p.y);
                end else begin
                    if (out_upd.code == disp[p]) begin
                        err_stream++;
                        $display("ERR %0t: update for cell (%0d,%0d) repeats code %0d",
                                 $time, p.x, p.y, out_upd.code);
                    end
                    disp[p] = out_upd.code;
                    upd_total[p]++;
                end
                received++;
                last_upd = cyc_no;
                if (received - returned > display_credits) begin
                    err_stream++;
                    $display("ERR %0t: %0d updates outstanding at the display",
                             $time, received - returned);
                end
                draw_delay(cur_delay, d);
                due = cyc_no + d;
                if (due <= last_due) due = last_due + 1; // One return pulse per cycle
                last_due = due;
                due_q.push_back(due);
            end
            @(posedge clk);
            #1;
            cyc_no++;
            credit_return = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc_no) begin
                void'(due_q.pop_front());
                credit_return = 1'b1;
                returned++;
            end
        end
    end

    initial begin
        bit ok;
        nrst       = 1'b0;
        scene      = '0;
        scene_load = 1'b0;
        read_scenes(ok);
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        if (!ok) begin
            err_frame++;
            $display("Could not read any scene from dv/snake_frame_input.txt");
        end else begin
            n_scenes = scenes.size();
            wait_quiet(); // Let the empty reset scene paint the border first
            for (int i = 0; i < n_scenes; i++) run_scene(i);
        end
        $display("Run done: %0d stream errors, %0d frame errors, %0d updates",
                 err_stream, err_frame, received);
        if (err_stream + err_frame == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (n_scenes > 0);
        repeat (n_scenes * 2000) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the run finishing", n_scenes * 2000);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/snake_frame_input.txt ====
# hx hy ax ay apple_valid body_count b0x b0y .. b7x b7y (hex), then max credit delay (decimal)
# Body slots at or above body_count carry filler that the classifier must ignore
7 5 c 8 1 3 6 5 5 5 4 5 0 0 0 0 0 0 0 0 0 0 3
7 5 c 8 1 3 6 5 5 5 4 5 0 0 0 0 0 0 0 0 0 0 5
8 5 c 8 1 3 7 5 6 5 5 5 0 0 0 0 0 0 0 0 0 0 0
8 6 c 8 1 5 8 5 7 5 6 5 5 5 4 5 0 0 0 0 0 0 40
9 6 c 8 1 5 8 6 8 5 7 5 6 5 5 5 0 0 0 0 0 0 90
0 6 f 3 1 3 1 6 2 6 3 6 0 0 0 0 0 0 0 0 0 0 10
5 4 9 9 1 3 5 4 5 5 5 6 a a b b c 9 d 2 3 3 2
a 3 2 9 1 8 9 3 8 3 7 3 6 3 6 4 6 5 6 6 6 7 60
a 3 2 9 1 8 9 3 8 3 7 3 6 3 6 4 6 5 6 6 6 7 60
b 3 2 9 1 8 a 3 9 3 8 3 7 3 6 3 6 4 6 5 2 9 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 20
3 2 e a 1 1 3 3 4 4 5 5 0 0 0 0 0 0 0 0 0 0 1

// ==== snake_frame_top.f ====
src/snake_frame_pkg.sv
src/cell_classifier.sv
src/frame_tracker.sv
src/update_sender.sv
src/snake_frame_top.sv
dv/snake_frame_assertions.sv
dv/snake_frame_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snake frame testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module snake_frame_tb \
    -f snake_frame_top.f -o sim_snake_frame

./obj_dir/sim_snake_frame > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
